// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - hdl/icache_pkg.sv
      - hdl/icache_ram.sv
      - hdl/icache_age.sv
      - hdl/icache_ctrl.sv
      - hdl/icache_top.sv
  - target: test
    files:
      - tb/icache_props.sv
      - tb/icache_checker.sv
      - tb/tb_icache.sv

// ==== files.f ====
hdl/icache_pkg.sv
hdl/icache_ram.sv
hdl/icache_age.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
tb/icache_props.sv
tb/icache_checker.sv
tb/tb_icache.sv

// ==== hdl/icache_age.sv ====
// per-set age counters for both ways
// counters saturate, a hit or fill clears the touched way
// victim pick for refill is combinational from the index

`timescale 1ns/10ps

module icache_age
    import icache_pkg::*;
#(
    parameter int SETS  = 64,
    parameter int AGE_W = 3
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [$clog2(SETS)-1:0] i_idx,
    input  logic                    i_tick,
    input  logic                    i_touch,
    input  logic                    i_touch_way,
    input  logic                    i_valid0,
    input  logic                    i_valid1,
    output logic                    o_victim
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    // age[way][set]
    logic [AGE_W-1:0] age [2][SETS];
    logic [AGE_W-1:0] age0_cur;
    logic [AGE_W-1:0] age1_cur;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    age[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    // touch wins over the tick
                    if (i_touch && (i_touch_way == w[0]) && (i_idx == s)) begin
                        age[w][s] <= '0;
                    end else if (i_tick && (age[w][s] != AGE_MAX)) begin
                        age[w][s] <= age[w][s] + 1'b1;
                    end
                end
            end
        end
    end

    assign age0_cur = age[0][i_idx];
    assign age1_cur = age[1][i_idx];

    // invalid way first, else the older one, tie to way 0
    always_comb begin
        if (!i_valid0) begin
            o_victim = WAY0;
        end else if (!i_valid1) begin
            o_victim = WAY1;
        end else if (age1_cur > age0_cur) begin
            o_victim = WAY1;
        end else begin
            o_victim = WAY0;
        end
    end

endmodule

// ==== hdl/icache_ctrl.sv ====
// cache controller FSM
// request latch, two-way tag compare, refill over the memory port,
// response hold under back-pressure and age unit events

`timescale 1ns/10ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // core request
    input  logic              i_req_valid,
    input  logic [ADDR_W-1:0] i_req_addr,
    output logic              o_req_ready,
    // core response
    output logic              o_rsp_valid,
    output word_t             o_rsp_data,
    input  logic              i_rsp_ready,
    // memory port
    output logic              o_mem_valid,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_ready,
    input  logic              i_mem_rvalid,
    input  word_t             i_mem_rdata,
    input  logic              i_flush,
    // ram side
    output logic [IDX_W-1:0]  o_idx,
    output logic              o_we0,
    output logic              o_we1,
    output tag_t              o_wtag,
    output word_t             o_wdata,
    output logic              o_flush,
    input  tag_t              i_tag0,
    input  tag_t              i_tag1,
    input  logic              i_tval0,
    input  logic              i_tval1,
    input  word_t             i_data0,
    input  word_t             i_data1,
    // age unit
    output logic              o_tick,
    output logic              o_touch,
    output logic              o_touch_way,
    input  logic              i_victim
);

    state_e            state;
    state_e            state_n;
    logic              ready_q;
    logic              rd_wait;
    logic [ADDR_W-1:0] addr_q;
    word_t             rsp_data_q;
    tag_t              req_tag;
    logic              accept;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              lookup_done;
    logic              fill;

    // flush has priority over a new request
    assign o_req_ready = ready_q && !i_flush;
    assign accept      = i_req_valid && o_req_ready;

    assign req_tag     = addr_q[TAG_LO +: TAG_W];
    assign hit0        = i_tval0 && (i_tag0 == req_tag);
    assign hit1        = i_tval1 && (i_tag1 == req_tag);
    assign hit         = hit0 || hit1;

    // ram output is valid in the second LOOKUP cycle
    assign lookup_done = (state == LOOKUP) && !rd_wait;

    // response may also arrive on the request handshake cycle
    assign fill = i_mem_rvalid &&
                  ((state == MISS_WAIT) || ((state == MISS_REQ) && i_mem_ready));

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_n = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!rd_wait) begin
                    state_n = hit ? RESP : MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (i_mem_ready) begin
                    state_n = fill ? RESP : MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (fill) begin
                    state_n = RESP;
                end
            end
            RESP: begin
                if (i_rsp_ready) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= IDLE;
            ready_q <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            state   <= state_n;
            ready_q <= (state_n == IDLE);
            rd_wait <= accept;
        end
    end

    // request address and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_req_addr;
        end
        if (lookup_done && hit) begin
            rsp_data_q <= hit0 ? i_data0 : i_data1;
        end else if (fill) begin
            rsp_data_q <= i_mem_rdata;
        end
    end

    assign o_rsp_valid = (state == RESP);
    assign o_rsp_data  = rsp_data_q;
    assign o_mem_valid = (state == MISS_REQ);
    assign o_mem_addr  = addr_q;

    // tag and data go into the victim way together
    assign o_idx   = addr_q[IDX_LO +: IDX_W];
    assign o_we0   = fill && (i_victim == WAY0);
    assign o_we1   = fill && (i_victim == WAY1);
    assign o_wtag  = req_tag;
    assign o_wdata = i_mem_rdata;
    assign o_flush = (state == IDLE) && i_flush;

    assign o_tick      = accept;
    assign o_touch     = (lookup_done && hit) || fill;
    assign o_touch_way = fill ? i_victim : (hit0 ? WAY0 : WAY1);

endmodule

// ==== hdl/icache_pkg.sv ====
// shared definitions for the two-way instruction cache
// address field split, payload types, controller states
// and the way encoding used by the age unit and the controller

package icache_pkg;

    // fetch address and instruction width
    localparam int ADDR_W = 64;
    localparam int DATA_W = 32;

    // index is address bits 8..3
    localparam int IDX_LO = 3;
    localparam int IDX_W  = 6;

    // tag takes everything above the index
    localparam int TAG_LO = IDX_LO + IDX_W;
    localparam int TAG_W  = ADDR_W - TAG_LO;

    // ram payloads
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [DATA_W-1:0] word_t;

    // way select values
    localparam logic WAY0 = 1'b0;
    localparam logic WAY1 = 1'b1;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        RESP
    } state_e;

endpackage

// ==== hdl/icache_ram.sv ====
// single-port ram for one cache way
// synchronous read, one valid bit per entry,
// valid vector cleared by reset or flush

`timescale 1ns/10ps

module icache_ram #(
    parameter int  SETS      = 64,
    parameter type payload_t = logic [31:0]
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [$clog2(SETS)-1:0] i_idx,
    input  logic                    i_we,
    input  payload_t                i_wdata,
    input  logic                    i_flush,
    output payload_t                o_rdata,
    output logic                    o_rvalid
);

    payload_t          mem [SETS];
    logic [SETS-1:0]   valid;

    // payload array, read registered
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_idx] <= i_wdata;
        end
        o_rdata <= mem[i_idx];
    end

    // valid bits and their read copy
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid    <= '0;
            o_rvalid <= 1'b0;
        end else begin
            if (i_flush) begin
                valid <= '0;
            end else if (i_we) begin
                valid[i_idx] <= 1'b1;
            end
            o_rvalid <= valid[i_idx];
        end
    end

endmodule

// ==== hdl/icache_top.sv ====
// two-way set-associative instruction cache top level
// controller, age unit, two tag rams and two data rams

`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
#(
    parameter int SETS  = 64,
    parameter int AGE_W = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req_valid,
    input  logic [ADDR_W-1:0] i_req_addr,
    output logic              o_req_ready,
    output logic              o_rsp_valid,
    output word_t             o_rsp_data,
    input  logic              i_rsp_ready,
    output logic              o_mem_valid,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_ready,
    input  logic              i_mem_rvalid,
    input  word_t             i_mem_rdata,
    input  logic              i_flush
);

    // set count has to match the index field
    if (SETS != (1 << IDX_W)) begin : g_sets_check
        $error("SETS must equal 2**IDX_W");
    end

    logic [IDX_W-1:0] idx;
    logic             we0;
    logic             we1;
    tag_t             wtag;
    word_t            wdata;
    logic             flush;
    tag_t             tag0;
    tag_t             tag1;
    logic             tval0;
    logic             tval1;
    word_t            data0;
    word_t            data1;
    logic             tick;
    logic             touch;
    logic             touch_way;
    logic             victim;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .o_req_ready  (o_req_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_data   (o_rsp_data),
        .i_rsp_ready  (i_rsp_ready),
        .o_mem_valid  (o_mem_valid),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rdata  (i_mem_rdata),
        .i_flush      (i_flush),
        .o_idx        (idx),
        .o_we0        (we0),
        .o_we1        (we1),
        .o_wtag       (wtag),
        .o_wdata      (wdata),
        .o_flush      (flush),
        .i_tag0       (tag0),
        .i_tag1       (tag1),
        .i_tval0      (tval0),
        .i_tval1      (tval1),
        .i_data0      (data0),
        .i_data1      (data1),
        .o_tick       (tick),
        .o_touch      (touch),
        .o_touch_way  (touch_way),
        .i_victim     (victim)
    );

    icache_age #(
        .SETS  (SETS),
        .AGE_W (AGE_W)
    ) u_age (
        .clk         (clk),
        .rst         (rst),
        .i_idx       (idx),
        .i_tick      (tick),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_valid0    (tval0),
        .i_valid1    (tval1),
        .o_victim    (victim)
    );

    // tag rams, their valid bits drive hit and victim logic
    icache_ram #(.SETS(SETS), .payload_t(tag_t)) u_tag0 (
        .clk      (clk),
        .rst      (rst),
        .i_idx    (idx),
        .i_we     (we0),
        .i_wdata  (wtag),
        .i_flush  (flush),
        .o_rdata  (tag0),
        .o_rvalid (tval0)
    );

    icache_ram #(.SETS(SETS), .payload_t(tag_t)) u_tag1 (
        .clk      (clk),
        .rst      (rst),
        .i_idx    (idx),
        .i_we     (we1),
        .i_wdata  (wtag),
        .i_flush  (flush),
        .o_rdata  (tag1),
        .o_rvalid (tval1)
    );

    // data rams, valid tracked by the tag side
    icache_ram #(.SETS(SETS), .payload_t(word_t)) u_data0 (
        .clk      (clk),
        .rst      (rst),
        .i_idx    (idx),
        .i_we     (we0),
        .i_wdata  (wdata),
        .i_flush  (flush),
        .o_rdata  (data0),
        .o_rvalid ()
    );

    icache_ram #(.SETS(SETS), .payload_t(word_t)) u_data1 (
        .clk      (clk),
        .rst      (rst),
        .i_idx    (idx),
        .i_we     (we1),
        .i_wdata  (wdata),
        .i_flush  (flush),
        .o_rdata  (data1),
        .o_rvalid ()
    );

endmodule

// ==== tb/icache_cases.txt ====
# columns: op (fetch/flush) address(hex) stall_cycles expected_hit
# set 5 holds tags 0, 1 and 2 to exercise the age rule
fetch 0000000000000028 0 0
fetch 0000000000000028 2 1
fetch 0000000000000228 0 0
fetch 0000000000000028 0 1
fetch 0000000000000428 1 0
fetch 0000000000000228 0 0
fetch 0000000000000428 3 1
fetch 0000000000000028 0 0
fetch 0000000000001000 0 0
fetch 0000000000001000 0 1
fetch ffff000000000040 0 0
fetch ffff000000000040 4 1
flush 0000000000000000 0 0
fetch 0000000000001000 0 0
fetch 0000000000000028 3 0
fetch 0000000000000028 0 1
fetch ffff000000000040 0 0
fetch 0000000000001000 1 1

// ==== tb/icache_checker.sv ====
// cache checker
// watches core and memory handshakes, keeps a reference
// valid/tag/age model and compares words, hit flags and timing

`timescale 1ns/10ps

module icache_checker
    import icache_pkg::*;
#(
    parameter int          SETS    = 64,
    parameter int          AGE_W   = 3,
    parameter logic [31:0] MEM_KEY = 32'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_req_valid,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  logic              i_req_ready,
    input  logic              i_rsp_valid,
    input  logic [DATA_W-1:0] i_rsp_data,
    input  logic              i_rsp_ready,
    input  logic              i_mem_valid,
    input  logic [ADDR_W-1:0] i_mem_addr,
    input  logic              i_mem_ready,
    input  logic              i_flush,
    input  logic              i_exp_hit,
    output int                o_errors,
    output int                o_checks,
    output int                o_rsp_count
);

    localparam int AGE_MAX = (1 << AGE_W) - 1;

    logic             mvalid [2][SETS];
    logic [TAG_W-1:0] mtag   [2][SETS];
    int               mage   [2][SETS];

    logic [ADDR_W-1:0] cur_addr;
    logic              cur_exp;
    int                mem_cnt;
    int                cyc;
    logic              rsp_seen;
    logic              held;
    logic [DATA_W-1:0] held_data;

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        o_checks++;
        if (got !== exp) begin
            o_errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // model update and checks for one accepted response
    task automatic finish_fetch();
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tg;
        logic             h0;
        logic             h1;
        int               vic;
        idx = cur_addr[IDX_LO +: IDX_W];
        tg  = cur_addr[TAG_LO +: TAG_W];
        h0  = mvalid[0][idx] && (mtag[0][idx] == tg);
        h1  = mvalid[1][idx] && (mtag[1][idx] == tg);
        compare("o_rsp_data", i_rsp_data, cur_addr[31:0] ^ MEM_KEY);
        compare("model hit", h0 || h1, cur_exp);
        if (h0 || h1) begin
            compare("mem requests on hit", mem_cnt, 0);
            mage[h0 ? 0 : 1][idx] = 0;
        end else begin
            compare("mem requests on miss", mem_cnt, 1);
            // invalid way first, else older, tie to way 0
            if (!mvalid[0][idx]) begin
                vic = 0;
            end else if (!mvalid[1][idx]) begin
                vic = 1;
            end else begin
                vic = (mage[1][idx] > mage[0][idx]) ? 1 : 0;
            end
            mvalid[vic][idx] = 1'b1;
            mtag[vic][idx]   = tg;
            mage[vic][idx]   = 0;
        end
        o_rsp_count++;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            compare("o_req_ready in reset", i_req_ready, 0);
            compare("o_rsp_valid in reset", i_rsp_valid, 0);
            compare("o_mem_valid in reset", i_mem_valid, 0);
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    mvalid[w][s] = 1'b0;
                    mage[w][s]   = 0;
                end
            end
            held     = 1'b0;
            rsp_seen = 1'b0;
        end else begin
            cyc++;
            if (i_flush) begin
                for (int w = 0; w < 2; w++) begin
                    for (int s = 0; s < SETS; s++) begin
                        mvalid[w][s] = 1'b0;
                    end
                end
            end
            if (i_rsp_valid && i_req_ready) begin
                o_errors++;
                $display("request ready was high during a pending response at %0t", $time);
            end
            // word must not move while the core stalls
            if (held && i_rsp_valid) begin
                compare("o_rsp_data held", i_rsp_data, held_data);
            end
            held      = i_rsp_valid && !i_rsp_ready;
            held_data = i_rsp_data;
            // accept edge, valid from edge +2, first seen at edge +3
            if (i_rsp_valid && !rsp_seen) begin
                rsp_seen = 1'b1;
                if (mem_cnt == 0) begin
                    compare("hit latency", cyc, 3);
                end
            end
            if (i_mem_valid && i_mem_ready) begin
                mem_cnt++;
                compare("o_mem_addr", i_mem_addr, cur_addr);
            end
            if (i_rsp_valid && i_rsp_ready) begin
                finish_fetch();
            end
            if (i_req_valid && i_req_ready) begin
                cur_addr = i_req_addr;
                cur_exp  = i_exp_hit;
                mem_cnt  = 0;
                cyc      = 0;
                rsp_seen = 1'b0;
                for (int w = 0; w < 2; w++) begin
                    for (int s = 0; s < SETS; s++) begin
                        if (mage[w][s] < AGE_MAX) begin
                            mage[w][s]++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        o_errors    = 0;
        o_checks    = 0;
        o_rsp_count = 0;
        mem_cnt     = 0;
        cyc         = 0;
    end

endmodule

// ==== tb/icache_props.sv ====
// handshake assertions for the cache controller
// memory request hold, response hold, ready/valid exclusion

`timescale 1ns/10ps

module icache_props
    import icache_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              o_mem_valid,
    input logic [ADDR_W-1:0] o_mem_addr,
    input logic              i_mem_ready,
    input logic              o_rsp_valid,
    input logic              i_rsp_ready,
    input logic              o_req_ready,
    input state_e            state
);

    int fails = 0;

    // memory request stays up with a stable address until taken
    a_mem_hold : assert property (@(posedge clk) disable iff (!rst)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr))
        else begin
            $error("memory request dropped or address changed before ready");
            fails++;
        end

    a_rsp_hold : assert property (@(posedge clk) disable iff (!rst)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid)
        else begin
            $error("response valid dropped before ready");
            fails++;
        end

    a_no_overlap : assert property (@(posedge clk) disable iff (!rst)
        !(o_req_ready && o_rsp_valid))
        else begin
            $error("request ready high while a response is pending");
            fails++;
        end

    // registered ready must track the IDLE state
    a_ready_idle : assert property (@(posedge clk) disable iff (!rst)
        o_req_ready |-> state == IDLE)
        else begin
            $error("request ready high outside IDLE");
            fails++;
        end

endmodule

bind icache_ctrl icache_props u_props (.*);

// ==== tb/tb_icache.sv ====
// testbench for the instruction cache
// clock and reset, cases file reader, core driver,
// memory model with random delays and the watchdog

`timescale 1ns/10ps

module tb_icache;

    localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;
    localparam int          MAX_CASES = 64;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [63:0] req_addr;
    logic        req_ready;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        rsp_ready;
    logic        mem_valid;
    logic [63:0] mem_addr;
    logic        mem_ready;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        flush;
    logic        exp_hit;

    int          errors;
    int          checks;
    int          rsp_count;
    int          n_cases;
    int          n_fetch;
    logic        is_flush [MAX_CASES];
    logic [63:0] case_addr [MAX_CASES];
    int          case_stall [MAX_CASES];
    logic        case_hit [MAX_CASES];

    icache_top #(.SETS(64), .AGE_W(3)) dut (
        .clk          (clk),
        .rst          (rst),
        .i_req_valid  (req_valid),
        .i_req_addr   (req_addr),
        .o_req_ready  (req_ready),
        .o_rsp_valid  (rsp_valid),
        .o_rsp_data   (rsp_data),
        .i_rsp_ready  (rsp_ready),
        .o_mem_valid  (mem_valid),
        .o_mem_addr   (mem_addr),
        .i_mem_ready  (mem_ready),
        .i_mem_rvalid (mem_rvalid),
        .i_mem_rdata  (mem_rdata),
        .i_flush      (flush)
    );

    icache_checker #(.SETS(64), .AGE_W(3), .MEM_KEY(MEM_KEY)) chk (
        .clk         (clk),
        .rst         (rst),
        .i_req_valid (req_valid),
        .i_req_addr  (req_addr),
        .i_req_ready (req_ready),
        .i_rsp_valid (rsp_valid),
        .i_rsp_data  (rsp_data),
        .i_rsp_ready (rsp_ready),
        .i_mem_valid (mem_valid),
        .i_mem_addr  (mem_addr),
        .i_mem_ready (mem_ready),
        .i_flush     (flush),
        .i_exp_hit   (exp_hit),
        .o_errors    (errors),
        .o_checks    (checks),
        .o_rsp_count (rsp_count)
    );

    always #10 clk = ~clk;

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        string op;
        logic [63:0] a;
        int    s;
        int    h;
        fd = $fopen("tb/icache_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %h %d %d", op, a, s, h);
            if (n == 4 && op != "#") begin
                is_flush[n_cases]   = (op == "flush");
                case_addr[n_cases]  = a;
                case_stall[n_cases] = s;
                case_hit[n_cases]   = h[0];
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_ready();
        do begin
            @(negedge clk);
        end while (!req_ready);
    endtask

    task automatic do_fetch(input logic [63:0] addr, input int stall, input logic hit);
        wait_ready();
        @(posedge clk);
        #2;
        exp_hit   = hit;
        req_valid = 1'b1;
        req_addr  = addr;
        wait_ready();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        do begin
            @(negedge clk);
        end while (!rsp_valid);
        @(posedge clk);
        #2;
        repeat (stall) begin
            @(posedge clk);
            #2;
        end
        rsp_ready = 1'b1;
        @(posedge clk);
        #2;
        rsp_ready = 1'b0;
        n_fetch++;
    endtask

    task automatic do_flush();
        wait_ready();
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
    endtask

    // memory model returns the low address bits xor a key
    initial begin
        logic [63:0] a;
        void'($urandom(17843));
        forever begin
            @(posedge clk);
            if (mem_valid) begin
                repeat ($urandom % 6) begin
                    @(posedge clk);
                end
                #2;
                mem_ready = 1'b1;
                a = mem_addr;
                @(posedge clk);
                #2;
                mem_ready = 1'b0;
                repeat ($urandom % 6) begin
                    @(posedge clk);
                    #2;
                end
                mem_rvalid = 1'b1;
                mem_rdata  = a[31:0] ^ MEM_KEY;
                @(posedge clk);
                #2;
                mem_rvalid = 1'b0;
            end
        end
    end

    // watchdog sized from the case count
    initial begin
        wait (n_cases > 0);
        repeat (n_cases * 40 + 8) begin
            @(posedge clk);
        end
        $display("timeout: the cases did not finish in the allowed time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int total;
        clk        = 1'b0;
        rst        = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        rsp_ready  = 1'b0;
        mem_ready  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        flush      = 1'b0;
        exp_hit    = 1'b0;
        n_cases    = 0;
        n_fetch    = 0;
        read_cases();
        repeat (8) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            if (is_flush[i]) begin
                do_flush();
            end else begin
                do_fetch(case_addr[i], case_stall[i], case_hit[i]);
            end
        end
        repeat (5) begin
            @(posedge clk);
        end
        total = errors + dut.u_ctrl.u_props.fails;
        if (n_cases == 0 || rsp_count != n_fetch) begin
            $display("response count %0d does not match %0d fetches", rsp_count, n_fetch);
            total++;
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_ctrl.u_props.fails);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
